// File: src.f
design/radio_cfg_pkg.sv
design/fe_regs_pkg.sv
design/fe_ctrl_if.sv
design/axil_fe_ctrl.sv
design/db_fe_channel.sv
design/db_io_map.sv
design/radio_fe_top.sv
verification/radio_fe_chk.sv
verification/radio_fe_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := radio_fe_tb
FILELIST  := src.f
FLAGS     := --binary --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/radio_fe_tb.sv
// self-checking testbench of radio_fe_top; stops at the first mismatch, fixed lfsr seed
`default_nettype none

module radio_fe_tb;
   import radio_cfg_pkg::*;
   import fe_regs_pkg::*;

   // reset reads + register tests + rx settings + board inputs
   localparam int N_ACC = NUM_CH * 5 + NUM_CH * 16 + 4 * NUM_CH + 2 * (2 * NUM_CH + 2);

   logic radio_clk;
   logic i_rst;
   logic [ADDR_W-1:0] i_s_axil_awaddr;
   logic i_s_axil_awvalid;
   logic o_s_axil_awready;
   logic [31:0] i_s_axil_wdata;
   logic i_s_axil_wvalid;
   logic o_s_axil_wready;
   axi_resp_t o_s_axil_bresp;
   logic o_s_axil_bvalid;
   logic i_s_axil_bready;
   logic [ADDR_W-1:0] i_s_axil_araddr;
   logic i_s_axil_arvalid;
   logic o_s_axil_arready;
   logic [31:0] o_s_axil_rdata;
   axi_resp_t o_s_axil_rresp;
   logic o_s_axil_rvalid;
   logic i_s_axil_rready;
   sample_t i_rx0;
   sample_t i_rx1;
   sample_t o_rx_data [NUM_CH];
   logic [NUM_CH-1:0] o_rx_stb;
   led_t  o_radio_led0;
   led_t  o_radio_led1;
   gpio_t o_db0_gpio_out;
   gpio_t o_db0_gpio_ddr;
   gpio_t i_db0_gpio_in;
   gpio_t o_radio0_misc_out;
   gpio_t i_radio0_misc_in;
   gpio_t o_db1_gpio_out;
   gpio_t o_db1_gpio_ddr;
   gpio_t i_db1_gpio_in;
   gpio_t o_radio1_misc_out;
   gpio_t i_radio1_misc_in;

   // shadow of the channel registers
   logic [1:0] sh_ctrl [NUM_CH];
   led_t       sh_led  [NUM_CH];
   gpio_t      sh_gout [NUM_CH];
   gpio_t      sh_gddr [NUM_CH];
   gpio_t      sh_mout [NUM_CH];
   logic [1:0] ctrl_prev [NUM_CH];
   sample_t    rx_prev [NUM_DB];
   gpio_t      misc_prev [NUM_DB];
   logic [15:0] lfsr = 16'd41497;
   logic        mon_en = 1'b0;

   radio_fe_top dut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   ////////////////////////////////////////////////////////////
   // random numbers and reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] rand_word(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // galois form of x16+x14+x13+x11+1
         r[i] = lfsr[0];
      end
      return r;
   endfunction

   function automatic sample_t exp_rx(input sample_t s, input logic [1:0] c);
      if (!c[0]) return '0;
      if (c[1]) return {s[15:0], s[31:16]};  // q moves up
      return s;
   endfunction

   function automatic logic [31:0] exp_rb(input int ch, input int r, output logic ok);
      gpio_t gin;
      gpio_t min;
      gin = (ch / 2 == 0) ? i_db0_gpio_in : i_db1_gpio_in;
      min = (ch / 2 == 0) ? i_radio0_misc_in : i_radio1_misc_in;
      ok = 1'b1;
      case (r)
         0: return {30'd0, sh_ctrl[ch]};
         1: return {29'd0, sh_led[ch]};
         2: return sh_gout[ch];
         3: return sh_gddr[ch];
         4: return sh_mout[ch];
         5: return (ch % 2 == 0) ? gin : '0;
         6: return (ch % 2 == 0) ? min : '0;
         default: begin
            ok = 1'b0;
            return '0;
         end
      endcase
   endfunction

   function automatic void apply_write(input int ch, input int r, input logic [31:0] d);
      case (r)
         0: sh_ctrl[ch] = d[1:0];
         1: sh_led[ch]  = d[2:0];
         2: sh_gout[ch] = d;
         3: sh_gddr[ch] = d;
         4: sh_mout[ch] = d;
         default: ;  // read only or unmapped
      endcase
   endfunction

   function automatic logic [ADDR_W-1:0] addr_of(input int ch, input int r);
      return {1'b0, ch_idx_t'(ch), reg_idx_t'(r), 2'(rand_word(2))};  // low bits ignored
   endfunction

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_sample(input string what, input sample_t got, input sample_t exp);
      if (got !== exp)
         report_fail($sformatf("Fail at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_gpio(input string what, input gpio_t got, input gpio_t exp);
      if (got !== exp)
         report_fail($sformatf("Fail at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_led(input string what, input led_t got, input led_t exp);
      if (got !== exp)
         report_fail($sformatf("Fail at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic check_resp(input string what, input axi_resp_t got, input axi_resp_t exp);
      if (got !== exp)
         report_fail($sformatf("Fail at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp)
         report_fail($sformatf("Fail at %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   ////////////////////////////////////////////////////////////
   // axi4-lite host
   ////////////////////////////////////////////////////////////

   task automatic axi_write(input int ch, input int r, input logic [31:0] data);
      logic [ADDR_W-1:0] a;
      axi_resp_t resp;
      int stall;
      a = addr_of(ch, r);
      @(posedge radio_clk);
      i_s_axil_awaddr  <= a;
      i_s_axil_wdata   <= data;
      i_s_axil_awvalid <= 1'b1;
      i_s_axil_wvalid  <= 1'b1;
      do @(negedge radio_clk); while (!o_s_axil_awready);
      @(posedge radio_clk);
      i_s_axil_awvalid <= 1'b0;
      i_s_axil_wvalid  <= 1'b0;
      apply_write(ch, r, data);
      @(negedge radio_clk);
      if (!o_s_axil_bvalid) report_fail("No write response after the write handshake");
      resp  = o_s_axil_bresp;
      stall = rand_word(2);
      repeat (stall) begin  // probe write with other data must not get in
         @(posedge radio_clk);
         i_s_axil_wdata   <= ~data;
         i_s_axil_awvalid <= 1'b1;
         i_s_axil_wvalid  <= 1'b1;
         @(negedge radio_clk);
         if (o_s_axil_awready) report_fail("Write accepted while a write response was pending");
      end
      @(posedge radio_clk);
      i_s_axil_awvalid <= 1'b0;
      i_s_axil_wvalid  <= 1'b0;
      i_s_axil_bready  <= 1'b1;
      @(posedge radio_clk);
      i_s_axil_bready  <= 1'b0;
      check_resp("bresp", resp, (r <= 4) ? RESP_OKAY : RESP_SLVERR);
   endtask

   task automatic read_check(input int ch, input int r);
      logic [31:0] data;
      logic [31:0] exp;
      logic ok;
      axi_resp_t resp;
      int stall;
      @(posedge radio_clk);
      i_s_axil_araddr  <= addr_of(ch, r);
      i_s_axil_arvalid <= 1'b1;
      do @(negedge radio_clk); while (!o_s_axil_arready);
      exp = exp_rb(ch, r, ok);  // value present on the handshake edge
      @(posedge radio_clk);
      i_s_axil_arvalid <= 1'b0;
      @(negedge radio_clk);
      if (!o_s_axil_rvalid) report_fail("No read data after the read handshake");
      data  = o_s_axil_rdata;
      resp  = o_s_axil_rresp;
      stall = rand_word(2);
      repeat (stall) begin
         @(posedge radio_clk);
         i_s_axil_arvalid <= 1'b1;
         @(negedge radio_clk);
         if (o_s_axil_arready) report_fail("Read accepted while read data was pending");
      end
      @(posedge radio_clk);
      i_s_axil_arvalid <= 1'b0;
      i_s_axil_rready  <= 1'b1;
      @(posedge radio_clk);
      i_s_axil_rready  <= 1'b0;
      check_gpio($sformatf("rdata ch%0d reg%0d", ch, r), data, exp);
      check_resp("rresp", resp, ok ? RESP_OKAY : RESP_SLVERR);
   endtask

   ////////////////////////////////////////////////////////////
   // pin and rx monitor
   ////////////////////////////////////////////////////////////

   always @(negedge radio_clk) begin
      if (mon_en) begin
         check_led("led0", o_radio_led0, sh_led[0] | sh_led[1]);
         check_led("led1", o_radio_led1, sh_led[2] | sh_led[3]);
         check_gpio("db0 gpio out", o_db0_gpio_out, sh_gout[0]);
         check_gpio("db0 gpio ddr", o_db0_gpio_ddr, sh_gddr[0]);
         check_gpio("db1 gpio out", o_db1_gpio_out, sh_gout[2]);
         check_gpio("db1 gpio ddr", o_db1_gpio_ddr, sh_gddr[2]);
         check_gpio("misc out 0", o_radio0_misc_out, misc_prev[0]);
         check_gpio("misc out 1", o_radio1_misc_out, misc_prev[1]);
         for (int c = 0; c < NUM_CH; c++) begin
            check_sample($sformatf("rx data %0d", c), o_rx_data[c],
                         exp_rx(rx_prev[c / 2], ctrl_prev[c]));
            check_bit($sformatf("rx stb %0d", c), o_rx_stb[c], ctrl_prev[c][0]);
         end
      end
      misc_prev[0] = sh_mout[0];
      misc_prev[1] = sh_mout[2];
      rx_prev[0]   = i_rx0;
      rx_prev[1]   = i_rx1;
      for (int c = 0; c < NUM_CH; c++) ctrl_prev[c] = sh_ctrl[c];
   end

   // new adc word every cycle
   initial begin
      forever begin
         @(posedge radio_clk);
         i_rx0 <= rand_word(32);
         i_rx1 <= rand_word(32);
      end
   end

   initial begin
      repeat (N_ACC * 20 + 8) @(posedge radio_clk);
      report_fail("Timeout, the tests did not finish in the expected time");
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      i_rst = 1'b1;
      {i_s_axil_awaddr, i_s_axil_awvalid, i_s_axil_wdata, i_s_axil_wvalid} = '0;
      {i_s_axil_bready, i_s_axil_araddr, i_s_axil_arvalid, i_s_axil_rready} = '0;
      {i_rx0, i_rx1, i_db0_gpio_in, i_db1_gpio_in} = '0;
      {i_radio0_misc_in, i_radio1_misc_in} = '0;
      for (int c = 0; c < NUM_CH; c++) begin
         {sh_ctrl[c], sh_led[c], sh_gout[c], sh_gddr[c], sh_mout[c]} = '0;
      end
      repeat (8) @(posedge radio_clk);
      i_rst <= 1'b0;
      repeat (2) @(posedge radio_clk);
      mon_en = 1'b1;
      // reset values
      for (int c = 0; c < NUM_CH; c++)
         for (int r = 0; r < 5; r++) read_check(c, r);
      // random register contents, bad indices
      for (int c = 0; c < NUM_CH; c++) begin
         for (int r = 0; r < 5; r++) axi_write(c, r, rand_word(32));
         for (int r = 5; r < 8; r++) axi_write(c, r, rand_word(32));
         for (int r = 0; r < 8; r++) read_check(c, r);
      end
      // rx path with random enable and swap
      repeat (4) begin
         for (int c = 0; c < NUM_CH; c++) axi_write(c, 0, rand_word(32));
         repeat (20) @(posedge radio_clk);
      end
      // board inputs and misc out
      repeat (2) begin
         @(posedge radio_clk);
         i_db0_gpio_in    <= rand_word(32);
         i_db1_gpio_in    <= rand_word(32);
         i_radio0_misc_in <= rand_word(32);
         i_radio1_misc_in <= rand_word(32);
         repeat (2) @(posedge radio_clk);
         for (int c = 0; c < NUM_CH; c++) begin
            read_check(c, 5);
            read_check(c, 6);
         end
         axi_write(0, 4, rand_word(32));
         axi_write(2, 4, rand_word(32));
      end
      repeat (4) @(posedge radio_clk);
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/radio_fe_chk.sv
// axi4-lite slave rules on the top-level ports, bound into radio_fe_top; needs assertions enabled
`default_nettype none

module radio_fe_chk (
   input wire logic                   radio_clk,
   input wire logic                   i_rst,
   input wire logic                   i_bready,
   input wire logic                   i_rready,
   input wire logic                   i_awready,
   input wire logic                   i_wready,
   input wire logic                   i_bvalid,
   input wire logic                   i_rvalid,
   input wire fe_regs_pkg::axi_resp_t i_bresp,
   input wire logic [31:0]            i_rdata
);

   ////////////////////////////////////////////////////////////
   // response channels hold until taken
   ////////////////////////////////////////////////////////////

   a_b_hold : assert property (@(posedge radio_clk) disable iff (i_rst)
      i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
      else $error("bvalid dropped or bresp changed before bready");

   a_r_hold : assert property (@(posedge radio_clk) disable iff (i_rst)
      i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata))
      else $error("rvalid dropped or rdata changed before rready");

   a_aw_w : assert property (@(posedge radio_clk) i_awready == i_wready)
      else $error("awready and wready differ");

   // second reset cycle onward
   a_rst : assert property (@(posedge radio_clk)
      i_rst && $past(i_rst) |-> !i_bvalid && !i_rvalid)
      else $error("valid output high during reset");

endmodule

bind radio_fe_top radio_fe_chk u_chk (
   .radio_clk (radio_clk),
   .i_rst     (i_rst),
   .i_bready  (i_s_axil_bready),
   .i_rready  (i_s_axil_rready),
   .i_awready (o_s_axil_awready),
   .i_wready  (o_s_axil_wready),
   .i_bvalid  (o_s_axil_bvalid),
   .i_rvalid  (o_s_axil_rvalid),
   .i_bresp   (o_s_axil_bresp),
   .i_rdata   (o_s_axil_rdata)
);

`default_nettype wire

// File: design/radio_fe_top.sv
// rx front end of two boards behind one axi4-lite slave, single clock, synchronous reset
`default_nettype none

module radio_fe_top #(
   parameter int AXI_ADDR_W = fe_regs_pkg::ADDR_W
) (
   input  logic                   radio_clk,
   input  logic                   i_rst,
   // host
   input  logic [AXI_ADDR_W-1:0]  i_s_axil_awaddr,
   input  logic                   i_s_axil_awvalid,
   output logic                   o_s_axil_awready,
   input  logic [31:0]            i_s_axil_wdata,
   input  logic                   i_s_axil_wvalid,
   output logic                   o_s_axil_wready,
   output fe_regs_pkg::axi_resp_t o_s_axil_bresp,
   output logic                   o_s_axil_bvalid,
   input  logic                   i_s_axil_bready,
   input  logic [AXI_ADDR_W-1:0]  i_s_axil_araddr,
   input  logic                   i_s_axil_arvalid,
   output logic                   o_s_axil_arready,
   output logic [31:0]            o_s_axil_rdata,
   output fe_regs_pkg::axi_resp_t o_s_axil_rresp,
   output logic                   o_s_axil_rvalid,
   input  logic                   i_s_axil_rready,
   // adc words and rx samples
   input  radio_cfg_pkg::sample_t i_rx0,
   input  radio_cfg_pkg::sample_t i_rx1,
   output radio_cfg_pkg::sample_t o_rx_data [radio_cfg_pkg::NUM_CH],
   output logic [radio_cfg_pkg::NUM_CH-1:0] o_rx_stb,
   // board 0
   output radio_cfg_pkg::led_t    o_radio_led0,
   output radio_cfg_pkg::gpio_t   o_db0_gpio_out,
   output radio_cfg_pkg::gpio_t   o_db0_gpio_ddr,
   input  radio_cfg_pkg::gpio_t   i_db0_gpio_in,
   output radio_cfg_pkg::gpio_t   o_radio0_misc_out,
   input  radio_cfg_pkg::gpio_t   i_radio0_misc_in,
   // board 1
   output radio_cfg_pkg::led_t    o_radio_led1,
   output radio_cfg_pkg::gpio_t   o_db1_gpio_out,
   output radio_cfg_pkg::gpio_t   o_db1_gpio_ddr,
   input  radio_cfg_pkg::gpio_t   i_db1_gpio_in,
   output radio_cfg_pkg::gpio_t   o_radio1_misc_out,
   input  radio_cfg_pkg::gpio_t   i_radio1_misc_in
);
   import radio_cfg_pkg::*;

   localparam int N_DB = NUM_DB;
   localparam int N_CH = NUM_CH;

   sample_t rx_in      [N_CH];
   led_t    leds       [N_CH];
   gpio_t   gpio_out   [N_CH];
   gpio_t   gpio_ddr   [N_CH];
   gpio_t   misc_out   [N_CH];
   gpio_t   gpio_in    [N_CH];
   gpio_t   misc_in    [N_CH];
   led_t    radio_led  [N_DB];
   gpio_t   db_gpio_out[N_DB];
   gpio_t   db_gpio_ddr[N_DB];
   gpio_t   db_gpio_in [N_DB];
   gpio_t   db_misc_out[N_DB];
   gpio_t   db_misc_in [N_DB];

   fe_ctrl_if fe [N_CH] ();

   ////////////////////////////////////////////////////////////
   // host control
   ////////////////////////////////////////////////////////////

   axil_fe_ctrl #(
      .AXI_ADDR_W (AXI_ADDR_W),
      .N_CH       (N_CH)
   ) u_ctrl (
      .radio_clk        (radio_clk),
      .i_rst            (i_rst),
      .i_s_axil_awaddr  (i_s_axil_awaddr),
      .i_s_axil_awvalid (i_s_axil_awvalid),
      .o_s_axil_awready (o_s_axil_awready),
      .i_s_axil_wdata   (i_s_axil_wdata),
      .i_s_axil_wvalid  (i_s_axil_wvalid),
      .o_s_axil_wready  (o_s_axil_wready),
      .o_s_axil_bresp   (o_s_axil_bresp),
      .o_s_axil_bvalid  (o_s_axil_bvalid),
      .i_s_axil_bready  (i_s_axil_bready),
      .i_s_axil_araddr  (i_s_axil_araddr),
      .i_s_axil_arvalid (i_s_axil_arvalid),
      .o_s_axil_arready (o_s_axil_arready),
      .o_s_axil_rdata   (o_s_axil_rdata),
      .o_s_axil_rresp   (o_s_axil_rresp),
      .o_s_axil_rvalid  (o_s_axil_rvalid),
      .i_s_axil_rready  (i_s_axil_rready),
      .fe               (fe)
   );

   ////////////////////////////////////////////////////////////
   // channels
   ////////////////////////////////////////////////////////////

   for (genvar c = 0; c < N_CH; c++) begin : g_ch
      assign rx_in[c] = (db_of(c) == 0) ? i_rx0 : i_rx1;  // both channels of a board, one adc

      db_fe_channel #(
         .CH_IDX (c)
      ) u_ch (
         .radio_clk  (radio_clk),
         .i_rst      (i_rst),
         .ctrl       (fe[c]),
         .i_rx       (rx_in[c]),
         .o_rx_data  (o_rx_data[c]),
         .o_rx_stb   (o_rx_stb[c]),
         .o_leds     (leds[c]),
         .o_gpio_out (gpio_out[c]),
         .o_gpio_ddr (gpio_ddr[c]),
         .o_misc_out (misc_out[c]),
         .i_gpio_in  (gpio_in[c]),
         .i_misc_in  (misc_in[c])
      );
   end

   db_io_map #(
      .N_DB (N_DB)
   ) u_io_map (
      .radio_clk        (radio_clk),
      .i_rst            (i_rst),
      .i_leds           (leds),
      .i_gpio_out       (gpio_out),
      .i_gpio_ddr       (gpio_ddr),
      .i_misc_out       (misc_out),
      .o_gpio_in        (gpio_in),
      .o_misc_in        (misc_in),
      .o_radio_led      (radio_led),
      .o_db_gpio_out    (db_gpio_out),
      .o_db_gpio_ddr    (db_gpio_ddr),
      .i_db_gpio_in     (db_gpio_in),
      .o_radio_misc_out (db_misc_out),
      .i_radio_misc_in  (db_misc_in)
   );

   // board pins
   assign o_radio_led0      = radio_led[0];
   assign o_db0_gpio_out    = db_gpio_out[0];
   assign o_db0_gpio_ddr    = db_gpio_ddr[0];
   assign db_gpio_in[0]     = i_db0_gpio_in;
   assign o_radio0_misc_out = db_misc_out[0];
   assign db_misc_in[0]     = i_radio0_misc_in;

   assign o_radio_led1      = radio_led[1];
   assign o_db1_gpio_out    = db_gpio_out[1];
   assign o_db1_gpio_ddr    = db_gpio_ddr[1];
   assign db_gpio_in[1]     = i_db1_gpio_in;
   assign o_radio1_misc_out = db_misc_out[1];
   assign db_misc_in[1]     = i_radio1_misc_in;

endmodule

`default_nettype wire

// File: design/db_io_map.sv
// even channel of each board owns gpio and misc pins, misc words pass one register stage
`default_nettype none

module db_io_map #(
   parameter  int N_DB = radio_cfg_pkg::NUM_DB,
   localparam int N_CH = N_DB * radio_cfg_pkg::CH_PER_DB
) (
   input  logic                 radio_clk,
   input  logic                 i_rst,
   // channel side
   input  radio_cfg_pkg::led_t  i_leds     [N_CH],
   input  radio_cfg_pkg::gpio_t i_gpio_out [N_CH],
   input  radio_cfg_pkg::gpio_t i_gpio_ddr [N_CH],
   input  radio_cfg_pkg::gpio_t i_misc_out [N_CH],
   output radio_cfg_pkg::gpio_t o_gpio_in  [N_CH],
   output radio_cfg_pkg::gpio_t o_misc_in  [N_CH],
   // board pins
   output radio_cfg_pkg::led_t  o_radio_led      [N_DB],
   output radio_cfg_pkg::gpio_t o_db_gpio_out    [N_DB],
   output radio_cfg_pkg::gpio_t o_db_gpio_ddr    [N_DB],
   input  radio_cfg_pkg::gpio_t i_db_gpio_in     [N_DB],
   output radio_cfg_pkg::gpio_t o_radio_misc_out [N_DB],
   input  radio_cfg_pkg::gpio_t i_radio_misc_in  [N_DB]
);
   import radio_cfg_pkg::*;

   gpio_t misc_in_r [N_DB];

   ////////////////////////////////////////////////////////////
   // per board
   ////////////////////////////////////////////////////////////

   for (genvar b = 0; b < N_DB; b++) begin : g_db
      // both channels light the same leds, shown as an overlay
      always_comb begin
         o_radio_led[b] = '0;
         for (int k = 0; k < CH_PER_DB; k++) begin
            o_radio_led[b] = o_radio_led[b] | i_leds[even_ch(b) + k];
         end
      end

      assign o_db_gpio_out[b] = i_gpio_out[even_ch(b)];  // odd channel unused
      assign o_db_gpio_ddr[b] = i_gpio_ddr[even_ch(b)];

      always_ff @(posedge radio_clk) begin
         if (i_rst) begin
            o_radio_misc_out[b] <= '0;
            misc_in_r[b]        <= '0;
         end else begin
            o_radio_misc_out[b] <= i_misc_out[even_ch(b)];
            misc_in_r[b]        <= i_radio_misc_in[b];
         end
      end
   end

   // inputs reach the even channel only
   for (genvar c = 0; c < N_CH; c++) begin : g_ch
      assign o_gpio_in[c] = is_even(c) ? i_db_gpio_in[db_of(c)] : '0;
      assign o_misc_in[c] = is_even(c) ? misc_in_r[db_of(c)] : '0;
   end

endmodule

`default_nettype wire

// File: design/db_fe_channel.sv
// one rx channel, no back-pressure on the sample path; CH_IDX must lie below NUM_CH
`default_nettype none

module db_fe_channel #(
   parameter int CH_IDX = 0
) (
   input  logic                   radio_clk,
   input  logic                   i_rst,
   fe_ctrl_if.chan                ctrl,
   // received samples
   input  radio_cfg_pkg::sample_t i_rx,
   output radio_cfg_pkg::sample_t o_rx_data,
   output logic                   o_rx_stb,
   // board i/o
   output radio_cfg_pkg::led_t    o_leds,
   output radio_cfg_pkg::gpio_t   o_gpio_out,
   output radio_cfg_pkg::gpio_t   o_gpio_ddr,
   output radio_cfg_pkg::gpio_t   o_misc_out,
   input  radio_cfg_pkg::gpio_t   i_gpio_in,
   input  radio_cfg_pkg::gpio_t   i_misc_in
);
   import radio_cfg_pkg::*;
   import fe_regs_pkg::*;

   logic [CTRL_W-1:0] ctrl_r;
   sample_t           rx_sel;

   if (CH_IDX < 0 || CH_IDX >= NUM_CH) begin : g_bad_idx
      $error("db_fe_channel: channel index out of range");
   end

   ////////////////////////////////////////////////////////////
   // register bank
   ////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         ctrl_r     <= '0;
         o_leds     <= '0;
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;
         o_misc_out <= '0;
      end else if (ctrl.set_stb) begin
         case (ctrl.set_addr)
            REG_FE_CTRL:  ctrl_r     <= ctrl.set_data[CTRL_W-1:0];
            REG_LEDS:     o_leds     <= ctrl.set_data[$bits(led_t)-1:0];
            REG_GPIO_OUT: o_gpio_out <= ctrl.set_data;
            REG_GPIO_DDR: o_gpio_ddr <= ctrl.set_data;
            REG_MISC_OUT: o_misc_out <= ctrl.set_data;
            default:      ;  // read only or unmapped
         endcase
      end
   end

   always_comb begin
      case (ctrl.set_addr)
         REG_FE_CTRL, REG_LEDS, REG_GPIO_OUT, REG_GPIO_DDR, REG_MISC_OUT:
            ctrl.set_ok = 1'b1;
         default:
            ctrl.set_ok = 1'b0;
      endcase
   end

   // readback
   always_comb begin
      ctrl.rb_ok   = 1'b1;
      ctrl.rb_data = '0;
      case (ctrl.rb_addr)
         REG_FE_CTRL:  ctrl.rb_data = {{(32-CTRL_W){1'b0}}, ctrl_r};
         REG_LEDS:     ctrl.rb_data = {{(32-$bits(led_t)){1'b0}}, o_leds};
         REG_GPIO_OUT: ctrl.rb_data = o_gpio_out;
         REG_GPIO_DDR: ctrl.rb_data = o_gpio_ddr;
         REG_MISC_OUT: ctrl.rb_data = o_misc_out;
         REG_GPIO_IN:  ctrl.rb_data = i_gpio_in;
         REG_MISC_IN:  ctrl.rb_data = i_misc_in;
         default:      ctrl.rb_ok   = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // rx path
   ////////////////////////////////////////////////////////////

   assign rx_sel = ctrl_r[CTRL_IQ_SWAP] ? {i_rx[15:0], i_rx[31:16]} : i_rx;  // q,i when swapped

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx_stb <= 1'b0;
      end else begin
         o_rx_stb <= ctrl_r[CTRL_RX_EN];
      end
   end

   always_ff @(posedge radio_clk) begin
      o_rx_data <= ctrl_r[CTRL_RX_EN] ? rx_sel : '0;  // zeros while gated
   end

endmodule

`default_nettype wire

// File: design/axil_fe_ctrl.sv
// axi4-lite slave, full-word writes only (no strobes), one access in flight per direction
`default_nettype none

module axil_fe_ctrl #(
   parameter int AXI_ADDR_W = fe_regs_pkg::ADDR_W,
   parameter int N_CH       = radio_cfg_pkg::NUM_CH
) (
   input  logic                   radio_clk,
   input  logic                   i_rst,
   // write address and data
   input  logic [AXI_ADDR_W-1:0]  i_s_axil_awaddr,
   input  logic                   i_s_axil_awvalid,
   output logic                   o_s_axil_awready,
   input  logic [31:0]            i_s_axil_wdata,
   input  logic                   i_s_axil_wvalid,
   output logic                   o_s_axil_wready,
   // write response
   output fe_regs_pkg::axi_resp_t o_s_axil_bresp,
   output logic                   o_s_axil_bvalid,
   input  logic                   i_s_axil_bready,
   // read address and data
   input  logic [AXI_ADDR_W-1:0]  i_s_axil_araddr,
   input  logic                   i_s_axil_arvalid,
   output logic                   o_s_axil_arready,
   output logic [31:0]            o_s_axil_rdata,
   output fe_regs_pkg::axi_resp_t o_s_axil_rresp,
   output logic                   o_s_axil_rvalid,
   input  logic                   i_s_axil_rready,
   // per-channel settings
   fe_ctrl_if.ctrl                fe [N_CH]
);
   import radio_cfg_pkg::*;
   import fe_regs_pkg::*;

   logic            wr_hs;
   logic            rd_hs;
   ch_idx_t         wr_ch;
   ch_idx_t         rd_ch;
   reg_idx_t        wr_reg;
   reg_idx_t        rd_reg;
   logic [N_CH-1:0] set_ok;
   logic [N_CH-1:0] rb_ok;
   logic [31:0]     rb_data [N_CH];

   // address decode
   assign wr_ch  = i_s_axil_awaddr[ADDR_CH_LSB +: $bits(ch_idx_t)];
   assign wr_reg = i_s_axil_awaddr[ADDR_REG_LSB +: $bits(reg_idx_t)];
   assign rd_ch  = i_s_axil_araddr[ADDR_CH_LSB +: $bits(ch_idx_t)];
   assign rd_reg = i_s_axil_araddr[ADDR_REG_LSB +: $bits(reg_idx_t)];

   // aw and w taken together, held off while a response waits
   assign wr_hs            = i_s_axil_awvalid && i_s_axil_wvalid && !o_s_axil_bvalid;
   assign o_s_axil_awready = wr_hs;
   assign o_s_axil_wready  = wr_hs;

   assign rd_hs            = i_s_axil_arvalid && !o_s_axil_rvalid;
   assign o_s_axil_arready = rd_hs;

   ////////////////////////////////////////////////////////////
   // channel fan-out
   ////////////////////////////////////////////////////////////

   for (genvar c = 0; c < N_CH; c++) begin : g_ch
      assign fe[c].set_stb  = wr_hs && (wr_ch == ch_idx_t'(c));  // addressed channel only
      assign fe[c].set_addr = wr_reg;
      assign fe[c].set_data = i_s_axil_wdata;
      assign fe[c].rb_addr  = rd_reg;
      assign set_ok[c]      = fe[c].set_ok;
      assign rb_ok[c]       = fe[c].rb_ok;
      assign rb_data[c]     = fe[c].rb_data;
   end

   ////////////////////////////////////////////////////////////
   // write response
   ////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_s_axil_bvalid <= 1'b0;
      end else if (wr_hs) begin
         o_s_axil_bvalid <= 1'b1;
      end else if (i_s_axil_bready) begin
         o_s_axil_bvalid <= 1'b0;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (wr_hs) begin
         o_s_axil_bresp <= set_ok[wr_ch] ? RESP_OKAY : RESP_SLVERR;
      end
   end

   ////////////////////////////////////////////////////////////
   // read data
   ////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_s_axil_rvalid <= 1'b0;
      end else if (rd_hs) begin
         o_s_axil_rvalid <= 1'b1;
      end else if (i_s_axil_rready) begin
         o_s_axil_rvalid <= 1'b0;
      end
   end

   // captured on the ar edge, held until rready
   always_ff @(posedge radio_clk) begin
      if (rd_hs) begin
         o_s_axil_rdata <= rb_ok[rd_ch] ? rb_data[rd_ch] : '0;
         o_s_axil_rresp <= rb_ok[rd_ch] ? RESP_OKAY : RESP_SLVERR;
      end
   end

endmodule

`default_nettype wire

// File: design/fe_ctrl_if.sv
// settings and readback path of one channel; set_ok, rb_ok and rb_data are combinational
`default_nettype none

interface fe_ctrl_if;
   import fe_regs_pkg::*;

   logic        set_stb;     // one-cycle write pulse
   reg_idx_t    set_addr;
   logic [31:0] set_data;
   logic        set_ok;      // set_addr is writable
   reg_idx_t    rb_addr;
   logic [31:0] rb_data;
   logic        rb_ok;       // rb_addr is readable

   modport ctrl (
      output set_stb, set_addr, set_data, rb_addr,
      input  set_ok, rb_data, rb_ok
   );

   modport chan (
      input  set_stb, set_addr, set_data, rb_addr,
      output set_ok, rb_data, rb_ok
   );

endinterface

`default_nettype wire

// File: design/fe_regs_pkg.sv
// register map of one front-end channel; address bits 6:5 channel, 4:2 register, 1:0 ignored
`default_nettype none

package fe_regs_pkg;

   localparam int ADDR_W = 8;        // axi4-lite address width

   // address layout
   localparam int ADDR_REG_LSB = 2;
   localparam int ADDR_CH_LSB  = 5;

   typedef logic [2:0] reg_idx_t;

   localparam reg_idx_t REG_FE_CTRL  = 3'd0;
   localparam reg_idx_t REG_LEDS     = 3'd1;
   localparam reg_idx_t REG_GPIO_OUT = 3'd2;
   localparam reg_idx_t REG_GPIO_DDR = 3'd3;
   localparam reg_idx_t REG_MISC_OUT = 3'd4;
   localparam reg_idx_t REG_GPIO_IN  = 3'd5;   // read only
   localparam reg_idx_t REG_MISC_IN  = 3'd6;   // read only

   // fe_ctrl fields
   localparam int CTRL_RX_EN   = 0;
   localparam int CTRL_IQ_SWAP = 1;
   localparam int CTRL_W       = 2;

   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: design/radio_cfg_pkg.sv
// two boards with two channels each, the channels of a board share one adc word; all words 32 bit
`default_nettype none

package radio_cfg_pkg;

   localparam int NUM_DB    = 2;
   localparam int CH_PER_DB = 2;
   localparam int NUM_CH    = NUM_DB * CH_PER_DB;

   typedef logic [31:0] sample_t;                // i in [31:16], q in [15:0]
   typedef logic [31:0] gpio_t;
   typedef logic [2:0]  led_t;                   // {rx, txrx_tx, txrx_rx}
   typedef logic [$clog2(NUM_CH)-1:0] ch_idx_t;

   ////////////////////////////////////////////////////////////
   // channel index helpers
   ////////////////////////////////////////////////////////////

   // board that owns a channel
   function automatic int db_of(input int ch);
      return ch / CH_PER_DB;
   endfunction

   // first channel of a board, the one wired to its pins
   function automatic int even_ch(input int db);
      return db * CH_PER_DB;
   endfunction

   function automatic bit is_even(input int ch);
      return (ch % CH_PER_DB) == 0;
   endfunction

endpackage

`default_nettype wire
